/* hw/rvPkg.sv */
package rvPkg;

    // data, address and instruction words
    typedef logic [31:0] wordT;

    // register index
    typedef logic [4:0] regAddrT;

    // major opcode
    // an all-zero instruction word acts as a bubble
    typedef logic [6:0] opcodeT;

    typedef logic [3:0] aluOpT;

    // source of an execute-stage operand
    typedef logic [1:0] fwdSelT;

    localparam int regCount = 32;

    localparam opcodeT opReg   = 7'b0110011;
    localparam opcodeT opImm   = 7'b0010011;
    localparam opcodeT opLoad  = 7'b0000011;
    localparam opcodeT opStore = 7'b0100011;

    localparam aluOpT aluAnd = 4'b0000;
    localparam aluOpT aluOr  = 4'b0001;
    localparam aluOpT aluAdd = 4'b0010;
    localparam aluOpT aluSub = 4'b0110;
    localparam aluOpT aluSll = 4'b1110;
    localparam aluOpT aluSrl = 4'b1101;
    localparam aluOpT aluSra = 4'b1111;

    localparam fwdSelT fwdNone = 2'b00;
    localparam fwdSelT fwdWb   = 2'b01;
    localparam fwdSelT fwdMem  = 2'b10;

endpackage

/* hw/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage (
    input  logic        clk,
    input  logic        rstN,
    input  logic        stall,
    input  rvPkg::wordT instr,
    output rvPkg::wordT instrAddr,
    output rvPkg::wordT idInstr
);

    rvPkg::wordT pc;

    // instruction port is combinational, so the pc is the fetch address
    assign instrAddr = pc;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
            // all-zero word decodes as a bubble
            idInstr <= '0;
        end else if (!stall) begin
            pc <= pc + 32'd4;
            idInstr <= instr;
        end
    end

endmodule

/* hw/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
    input  logic           clk,
    input  logic           rstN,
    input  rvPkg::wordT    idInstr,
    input  logic           wbRegWrite,
    input  rvPkg::regAddrT wbRd,
    input  rvPkg::wordT    wbValue,
    input  rvPkg::regAddrT exRd,
    input  logic           exMemRead,
    output logic           stall,
    output rvPkg::wordT    exOpA,
    output rvPkg::wordT    exOpB,
    output rvPkg::wordT    exImm,
    output rvPkg::regAddrT exRs1,
    output rvPkg::regAddrT exRs2,
    output rvPkg::regAddrT exRdOut,
    output rvPkg::aluOpT   exAluOp,
    output logic           exAluSrc,
    output logic           exMemReadOut,
    output logic           exMemWrite,
    output logic           exRegWrite
);

    rvPkg::wordT    regFile [rvPkg::regCount];
    rvPkg::opcodeT  opcode;
    logic [2:0]     funct3;
    rvPkg::regAddrT rs1;
    rvPkg::regAddrT rs2;
    rvPkg::regAddrT rd;
    rvPkg::wordT    imm;
    rvPkg::wordT    opA;
    rvPkg::wordT    opB;
    rvPkg::aluOpT   aluOp;
    logic           aluSrc;
    logic           memRead;
    logic           memWrite;
    logic           regWrite;
    logic           usesRs1;
    logic           usesRs2;

    assign opcode = idInstr[6:0];
    assign funct3 = idInstr[14:12];
    assign rs1    = idInstr[19:15];
    assign rs2    = idInstr[24:20];
    assign rd     = idInstr[11:7];

    always_comb begin
        aluSrc   = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        regWrite = 1'b0;
        usesRs1  = 1'b0;
        usesRs2  = 1'b0;
        aluOp    = rvPkg::aluAdd;
        case (opcode)
            rvPkg::opReg, rvPkg::opImm: begin
                regWrite = 1'b1;
                usesRs1  = 1'b1;
                usesRs2  = (opcode == rvPkg::opReg);
                aluSrc   = (opcode == rvPkg::opImm);
                case (funct3)
                    // bit 30 selects sub only for the register form
                    3'b000: aluOp = (opcode == rvPkg::opReg && idInstr[30]) ?
                                    rvPkg::aluSub : rvPkg::aluAdd;
                    3'b001: aluOp = rvPkg::aluSll;
                    3'b101: aluOp = idInstr[30] ? rvPkg::aluSra : rvPkg::aluSrl;
                    3'b110: aluOp = rvPkg::aluOr;
                    3'b111: aluOp = rvPkg::aluAnd;
                    default: aluOp = rvPkg::aluAdd;
                endcase
            end
            rvPkg::opLoad: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
                aluSrc   = 1'b1;
                usesRs1  = 1'b1;
            end
            rvPkg::opStore: begin
                // rs2 of a store is forwarded in the memory stage instead
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                usesRs1  = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // S-type for stores, I-type otherwise
    always_comb begin
        if (opcode == rvPkg::opStore) begin
            imm = {{20{idInstr[31]}}, idInstr[31:25], idInstr[11:7]};
        end else begin
            imm = {{20{idInstr[31]}}, idInstr[31:20]};
        end
    end

    always_ff @(posedge clk) begin
        if (wbRegWrite && wbRd != '0) begin
            regFile[wbRd] <= wbValue;
        end
    end

    // same-cycle writeback bypass with x0 reading as zero
    always_comb begin
        if (rs1 == '0) begin
            opA = '0;
        end else if (wbRegWrite && wbRd == rs1) begin
            opA = wbValue;
        end else begin
            opA = regFile[rs1];
        end
        if (rs2 == '0) begin
            opB = '0;
        end else if (wbRegWrite && wbRd == rs2) begin
            opB = wbValue;
        end else begin
            opB = regFile[rs2];
        end
    end

    // load in execute feeding this instruction
    assign stall = exMemRead && exRd != '0 &&
                   ((usesRs1 && exRd == rs1) || (usesRs2 && exRd == rs2));

    always_ff @(posedge clk) begin
        if (!rstN || stall) begin
            exMemReadOut <= 1'b0;
            exMemWrite   <= 1'b0;
            exRegWrite   <= 1'b0;
        end else begin
            exMemReadOut <= memRead;
            exMemWrite   <= memWrite;
            exRegWrite   <= regWrite;
        end
        exOpA    <= opA;
        exOpB    <= opB;
        exImm    <= imm;
        exRs1    <= rs1;
        exRs2    <= rs2;
        exRdOut  <= rd;
        exAluOp  <= aluOp;
        exAluSrc <= aluSrc;
    end

endmodule

/* hw/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
    input  logic           clk,
    input  logic           rstN,
    input  rvPkg::wordT    exOpA,
    input  rvPkg::wordT    exOpB,
    input  rvPkg::wordT    exImm,
    input  rvPkg::regAddrT exRs1,
    input  rvPkg::regAddrT exRs2,
    input  rvPkg::regAddrT exRd,
    input  rvPkg::aluOpT   exAluOp,
    input  logic           exAluSrc,
    input  logic           exMemRead,
    input  logic           exMemWrite,
    input  logic           exRegWrite,
    input  rvPkg::regAddrT memRd,
    input  rvPkg::regAddrT wbRd,
    input  logic           memRegWrite,
    input  logic           wbRegWrite,
    input  rvPkg::wordT    memValue,
    input  rvPkg::wordT    wbValue,
    output rvPkg::wordT    memAluResult,
    output rvPkg::wordT    memStoreData,
    output rvPkg::regAddrT memRdOut,
    output rvPkg::regAddrT memRs2,
    output logic           memMemRead,
    output logic           memMemWrite,
    output logic           memRegWriteOut
);

    rvPkg::fwdSelT fwdA;
    rvPkg::fwdSelT fwdB;
    rvPkg::wordT   srcA;
    rvPkg::wordT   srcB;
    rvPkg::wordT   aluB;
    rvPkg::wordT   aluResult;

    // memory stage wins over writeback and x0 is never forwarded
    always_comb begin
        if (memRegWrite && memRd != '0 && memRd == exRs1) begin
            fwdA = rvPkg::fwdMem;
        end else if (wbRegWrite && wbRd != '0 && wbRd == exRs1) begin
            fwdA = rvPkg::fwdWb;
        end else begin
            fwdA = rvPkg::fwdNone;
        end
        if (memRegWrite && memRd != '0 && memRd == exRs2) begin
            fwdB = rvPkg::fwdMem;
        end else if (wbRegWrite && wbRd != '0 && wbRd == exRs2) begin
            fwdB = rvPkg::fwdWb;
        end else begin
            fwdB = rvPkg::fwdNone;
        end
    end

    always_comb begin
        case (fwdA)
            rvPkg::fwdMem: srcA = memValue;
            rvPkg::fwdWb:  srcA = wbValue;
            default:       srcA = exOpA;
        endcase
        case (fwdB)
            rvPkg::fwdMem: srcB = memValue;
            rvPkg::fwdWb:  srcB = wbValue;
            default:       srcB = exOpB;
        endcase
    end

    assign aluB = exAluSrc ? exImm : srcB;

    // shift amount is the low 5 bits of operand B
    always_comb begin
        case (exAluOp)
            rvPkg::aluAnd: aluResult = srcA & aluB;
            rvPkg::aluOr:  aluResult = srcA | aluB;
            rvPkg::aluSub: aluResult = srcA - aluB;
            rvPkg::aluSll: aluResult = srcA << aluB[4:0];
            rvPkg::aluSrl: aluResult = srcA >> aluB[4:0];
            rvPkg::aluSra: aluResult = $signed(srcA) >>> aluB[4:0];
            default:       aluResult = srcA + aluB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            memMemRead     <= 1'b0;
            memMemWrite    <= 1'b0;
            memRegWriteOut <= 1'b0;
        end else begin
            memMemRead     <= exMemRead;
            memMemWrite    <= exMemWrite;
            memRegWriteOut <= exRegWrite;
        end
        memAluResult <= aluResult;
        // forwarded rs2 that a load in writeback may still replace
        memStoreData <= srcB;
        memRdOut     <= exRd;
        memRs2       <= exRs2;
    end

endmodule

/* hw/memWriteback.sv */
`timescale 1ns/1ps

module memWriteback #(
    parameter int dmemAddrBits = 6
) (
    input  logic           clk,
    input  logic           rstN,
    input  rvPkg::wordT    memAluResult,
    input  rvPkg::wordT    memStoreData,
    input  rvPkg::regAddrT memRd,
    input  rvPkg::regAddrT memRs2,
    input  logic           memMemRead,
    input  logic           memMemWrite,
    input  logic           memRegWrite,
    output rvPkg::wordT    memValue,
    output logic           wbRegWrite,
    output rvPkg::regAddrT wbRd,
    output rvPkg::wordT    wbValue,
    output logic           wbValid
);

    rvPkg::wordT             dmem [2**dmemAddrBits];
    logic [dmemAddrBits-1:0] dmemAddr;
    logic                    wbMemRead;
    logic                    storeFwd;
    rvPkg::wordT             storeData;
    rvPkg::wordT             readData;

    // word addressed with the byte offset ignored
    assign dmemAddr = memAluResult[dmemAddrBits+1:2];

    // store of a register that the load in writeback just produced
    assign storeFwd  = memMemWrite && wbMemRead && wbRegWrite &&
                       wbRd != '0 && wbRd == memRs2;
    assign storeData = storeFwd ? wbValue : memStoreData;

    always_ff @(posedge clk) begin
        if (memMemWrite) begin
            dmem[dmemAddr] <= storeData;
        end
    end

    assign readData = dmem[dmemAddr];

    // ALU result is what the memory stage can forward
    assign memValue = memAluResult;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbRegWrite <= 1'b0;
            wbMemRead  <= 1'b0;
        end else begin
            wbRegWrite <= memRegWrite;
            wbMemRead  <= memMemRead;
        end
        wbRd    <= memRd;
        wbValue <= memMemRead ? readData : memAluResult;
    end

    assign wbValid = wbRegWrite && wbRd != '0;

endmodule

/* hw/rvPipeTop.sv */
`timescale 1ns/1ps

module rvPipeTop #(
    parameter int dmemAddrBits = 6
) (
    input  logic           clk,
    input  logic           rstN,
    input  rvPkg::wordT    instr,
    output rvPkg::wordT    instrAddr,
    output logic           wbValid,
    output rvPkg::regAddrT wbRd,
    output rvPkg::wordT    wbData
);

    logic           stall;
    rvPkg::wordT    idInstr;

    // decode/execute fields
    rvPkg::wordT    exOpA;
    rvPkg::wordT    exOpB;
    rvPkg::wordT    exImm;
    rvPkg::regAddrT exRs1;
    rvPkg::regAddrT exRs2;
    rvPkg::regAddrT exRd;
    rvPkg::aluOpT   exAluOp;
    logic           exAluSrc;
    logic           exMemRead;
    logic           exMemWrite;
    logic           exRegWrite;

    // execute/memory fields
    rvPkg::wordT    memAluResult;
    rvPkg::wordT    memStoreData;
    rvPkg::regAddrT memRd;
    rvPkg::regAddrT memRs2;
    logic           memMemRead;
    logic           memMemWrite;
    logic           memRegWrite;
    rvPkg::wordT    memValue;

    logic           wbRegWrite;
    rvPkg::wordT    wbValue;

    assign wbData = wbValue;

    fetchStage i_fetchStage (
        .clk       (clk),
        .rstN      (rstN),
        .stall     (stall),
        .instr     (instr),
        .instrAddr (instrAddr),
        .idInstr   (idInstr)
    );

    decodeStage i_decodeStage (
        .clk          (clk),
        .rstN         (rstN),
        .idInstr      (idInstr),
        .wbRegWrite   (wbRegWrite),
        .wbRd         (wbRd),
        .wbValue      (wbValue),
        .exRd         (exRd),
        .exMemRead    (exMemRead),
        .stall        (stall),
        .exOpA        (exOpA),
        .exOpB        (exOpB),
        .exImm        (exImm),
        .exRs1        (exRs1),
        .exRs2        (exRs2),
        .exRdOut      (exRd),
        .exAluOp      (exAluOp),
        .exAluSrc     (exAluSrc),
        .exMemReadOut (exMemRead),
        .exMemWrite   (exMemWrite),
        .exRegWrite   (exRegWrite)
    );

    executeStage i_executeStage (
        .clk            (clk),
        .rstN           (rstN),
        .exOpA          (exOpA),
        .exOpB          (exOpB),
        .exImm          (exImm),
        .exRs1          (exRs1),
        .exRs2          (exRs2),
        .exRd           (exRd),
        .exAluOp        (exAluOp),
        .exAluSrc       (exAluSrc),
        .exMemRead      (exMemRead),
        .exMemWrite     (exMemWrite),
        .exRegWrite     (exRegWrite),
        .memRd          (memRd),
        .wbRd           (wbRd),
        .memRegWrite    (memRegWrite),
        .wbRegWrite     (wbRegWrite),
        .memValue       (memValue),
        .wbValue        (wbValue),
        .memAluResult   (memAluResult),
        .memStoreData   (memStoreData),
        .memRdOut       (memRd),
        .memRs2         (memRs2),
        .memMemRead     (memMemRead),
        .memMemWrite    (memMemWrite),
        .memRegWriteOut (memRegWrite)
    );

    memWriteback #(
        .dmemAddrBits (dmemAddrBits)
    ) i_memWriteback (
        .clk          (clk),
        .rstN         (rstN),
        .memAluResult (memAluResult),
        .memStoreData (memStoreData),
        .memRd        (memRd),
        .memRs2       (memRs2),
        .memMemRead   (memMemRead),
        .memMemWrite  (memMemWrite),
        .memRegWrite  (memRegWrite),
        .memValue     (memValue),
        .wbRegWrite   (wbRegWrite),
        .wbRd         (wbRd),
        .wbValue      (wbValue),
        .wbValid      (wbValid)
    );

endmodule

/* sim/rvPipeTb.sv */
`timescale 1ns/1ps

module rvPipeTb;

    localparam int maxWords = 256;

    logic           clk;
    logic           rstN;
    rvPkg::wordT    instr;
    rvPkg::wordT    instrAddr;
    logic           wbValid;
    rvPkg::regAddrT wbRd;
    rvPkg::wordT    wbData;

    rvPkg::wordT    prog [maxWords];
    rvPkg::regAddrT expRd [maxWords];
    rvPkg::wordT    expData [maxWords];
    int             progCount = 0;
    int             expCount = 0;
    int             expIdx = 0;
    int             cycleCount = 0;
    int             cycleLimit = 0;
    bit             loadOk;

    rvPipeTop i_rvPipeTop (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .instrAddr (instrAddr),
        .wbValid   (wbValid),
        .wbRd      (wbRd),
        .wbData    (wbData)
    );

    // instruction port returns a bubble past the end of the program
    assign instr = ({2'b00, instrAddr[31:2]} < progCount) ? prog[instrAddr[9:2]] : '0;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    // one "I" line per program word, one "W" line per expected writeback
    task automatic loadTestData(output bit ok);
        int          fd;
        int          code;
        logic [7:0]  tag;
        rvPkg::wordT word;
        int          rd;
        logic [8*128-1:0] rest;
        bit          bad;
        ok = 1'b0;
        bad = 1'b0;
        fd = $fopen("sim/rvPipeTestdata.txt", "r");
        if (fd != 0) begin
            code = $fscanf(fd, "%s", tag);
            while (code == 1 && !bad) begin
                if (tag == "#") begin
                    code = $fgets(rest, fd);
                end else if (tag == "I" && progCount < maxWords) begin
                    code = $fscanf(fd, "%h", word);
                    bad = (code != 1);
                    prog[progCount] = word;
                    progCount++;
                end else if (tag == "W" && expCount < maxWords) begin
                    code = $fscanf(fd, "%d %h", rd, word);
                    bad = (code != 2);
                    expRd[expCount] = rd[4:0];
                    expData[expCount] = word;
                    expCount++;
                end else begin
                    bad = 1'b1;
                end
                code = $fscanf(fd, "%s", tag);
            end
            $fclose(fd);
            ok = !bad && progCount > 0 && expCount > 0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // retired writes checked against the expected records in program order
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (rstN === 1'b1 && wbValid === 1'b1) begin
            if (expIdx >= expCount) begin
                abortRun($sformatf("unexpected writeback to x%0d at %0t with no record left",
                                   wbRd, $time));
            end else begin
                assert (wbRd == expRd[expIdx])
                else abortRun($sformatf("CHECK FAILED at %0t: wbRd is %0d, expected %0d",
                                        $time, wbRd, expRd[expIdx]));
                assert (wbData == expData[expIdx])
                else abortRun($sformatf("CHECK FAILED at %0t: wbData is %h, expected %h",
                                        $time, wbData, expData[expIdx]));
                expIdx = expIdx + 1;
            end
        end
    end

    initial begin
        rstN = 1'b0;
        loadTestData(loadOk);
        if (!loadOk) begin
            abortRun("could not read program and records from sim/rvPipeTestdata.txt");
        end else begin
            cycleLimit = 5 * progCount + 20;
            repeat (8) @(posedge clk);
            #1 rstN = 1'b1;
            while (expIdx < expCount && cycleCount < cycleLimit) begin
                @(negedge clk);
            end
            if (expIdx == expCount) begin
                // let the pipeline drain so a stray strobe is still caught
                repeat (8) @(negedge clk);
                $display("Finished with no errors");
                $finish;
            end else begin
                abortRun($sformatf("timeout after %0d cycles, %0d writebacks missing",
                                   cycleCount, expCount - expIdx));
            end
        end
    end

endmodule

/* rvPipeTop.f */
hw/rvPkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memWriteback.sv
hw/rvPipeTop.sv
sim/rvPipeTb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert --top-module rvPipeTb -f rvPipeTop.f --Mdir obj_dir
	@out=$$(./obj_dir/VrvPipeTb); echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

/* sim/rvPipeTestdata.txt */
# I <instruction word in hex>
# W <rd in decimal> <write data in hex>
I 00500093
I F9C00113
I 002081B3
I 40118233
I 401252B3
I 00125333
I 001093B3
I 0023F433
I 001464B3
I 0F017513
I 00F56593
I 00409613
I 01C15693
I 40415713
I 00302023
I 00902423
I 00002783
I 00178833
I 00802883
I 01102223
I 00402903
I 00708013
I 00108033
I 012009B3
W 1 00000005
W 2 FFFFFF9C
W 3 FFFFFFA1
W 4 FFFFFF9C
W 5 FFFFFFFC
W 6 07FFFFFC
W 7 000000A0
W 8 00000080
W 9 00000085
W 10 00000090
W 11 0000009F
W 12 00000050
W 13 0000000F
W 14 FFFFFFF9
W 15 FFFFFFA1
W 16 FFFFFFA6
W 17 00000085
W 18 00000085
W 19 00000085
